//--- core.f
source/core_pkg.sv
source/hazard_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/core.sv
verif/core_assertions.sv
verif/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_core -f core.f

# Runtime failure is judged by the pass line below
out=$(./obj_dir/Vtb_core 2>&1) || true
echo "$out"

echo "$out" | grep -qx "test passed"

//--- verif/core_patterns.hex
// Program count, program words; preload count, (word addr, value) pairs;
// expected count, (word addr, expected value) pairs. All values hex
0000002F
00002083 00402103 002081B3 04302023
40208233 001122B3 00113333 04402223
04502423 04602623 123453B7 6783E393
40215413 01C15493 00439513 FFF3C593
009506B3 00B3F633 04702823 04802A23
04902C23 04A02E23 06B02023 06D02223
06C02423 00508013 06002623 00108663
06202823 06202A23 00209463 06202C23
00114463 06202E23 0020D463 08202023
00115463 08102223 0020C463 08202423
00208463 00109463 08402623 0080076F
08202823 08E02A23 0000006F
// Preload
0000000B
000 00000007  001 FFFFFFF0  013 11111111  01A 11111111
01B DEADBEEF  01C 11111111  01D 11111111  01E 11111111
01F 11111111  020 11111111  024 11111111
// Expected
00000016
010 FFFFFFF7  011 00000017  012 00000001  013 00000000
014 12345678  015 FFFFFFFC  016 0000000F  017 23456780
018 EDCBA987  019 2345678F  01A 00000000  01B 00000000
01C 11111111  01D 11111111  01E 11111111  01F 11111111
020 11111111  021 00000007  022 FFFFFFF0  023 00000017
024 11111111  025 000000B0

//--- verif/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic clk
);
	initial clk = 1'b0;
	always #10 clk = ~clk;	// 20 ns period
endmodule

module tb_core import core_pkg::*; ();

	logic clk;
	logic arst_n;
	logic run;
	logic prog_write;
	logic [IMEM_AW-1:0] prog_addr;
	logic [XLEN-1:0] prog_data;
	logic [3:0] con_write;
	logic [DMEM_AW-1:0] con_addr;
	logic [XLEN-1:0] con_in;
	logic [XLEN-1:0] con_out;

	logic [31:0] pat [0:255];	// Whole pattern file
	int limit_cycles;
	logic limit_ready;

	clock_gen u_clock_gen (.clk);

	core u_core (.clk, .arst_n, .run, .prog_write, .prog_addr, .prog_data,
		.con_write, .con_addr, .con_in, .con_out);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic write_prog(input logic [IMEM_AW-1:0] a, input logic [XLEN-1:0] d);
		@(posedge clk);
		prog_write <= 1'b1;
		prog_addr <= a;
		prog_data <= d;
	endtask

	task automatic write_data(input logic [DMEM_AW-1:0] a, input logic [XLEN-1:0] d,
		input logic [3:0] strobe);
		@(posedge clk);
		con_write <= strobe;
		con_addr <= a;
		con_in <= d;
	endtask

	// Address sampled on one edge, data valid after the next
	task automatic read_word(input logic [DMEM_AW-1:0] a, output logic [XLEN-1:0] d);
		@(posedge clk);
		con_write <= 4'b0000;
		con_addr <= a;
		@(posedge clk);
		@(negedge clk);
		d = con_out;
	endtask

	// Watchdog, armed once the pattern sizes are known
	initial begin
		wait (limit_ready === 1'b1);
		repeat (limit_cycles) @(posedge clk);
		fail_run("Timeout: the test did not finish in time");
	end

	initial begin
		int n_prog;
		int n_pre;
		int n_exp;
		int idx;
		logic [XLEN-1:0] got;
		logic [XLEN-1:0] old_word;
		logic [XLEN-1:0] new_word;
		logic [3:0] strobe;

		arst_n = 1'b0;
		run = 1'b0;
		prog_write = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		con_write = 4'b0000;
		con_addr = '0;
		con_in = '0;
		limit_ready = 1'b0;
		limit_cycles = 0;

		$readmemh("verif/core_patterns.hex", pat);
		n_prog = int'(pat[0]);
		n_pre = int'(pat[n_prog + 1]);
		n_exp = int'(pat[n_prog + 2 + 2 * n_pre]);
		limit_cycles = 5 * n_prog + 40 + n_pre + 3 * n_exp + 200 + 20;
		limit_ready = 1'b1;

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < n_prog; i++)
			write_prog(IMEM_AW'(i), pat[1 + i]);
		@(posedge clk);
		prog_write <= 1'b0;

		idx = n_prog + 2;
		for (int i = 0; i < n_pre; i++)
			write_data(DMEM_AW'(pat[idx + 2 * i]), pat[idx + 2 * i + 1], 4'b1111);
		@(posedge clk);
		con_write <= 4'b0000;

		// Run window of 4 cycles per program word plus 40
		run <= 1'b1;
		repeat (4 * n_prog + 40) @(posedge clk);
		run <= 1'b0;
		repeat (10) @(posedge clk);

		idx = n_prog + 3 + 2 * n_pre;
		for (int i = 0; i < n_exp; i++) begin
			read_word(DMEM_AW'(pat[idx + 2 * i]), got);
			check_word($sformatf("dmem[%0d]", pat[idx + 2 * i]), got, pat[idx + 2 * i + 1]);
		end

		// Partial strobes on a word the program never touches
		old_word = 32'haabb_ccdd;
		new_word = 32'h1122_3344;
		strobe = 4'b0101;
		write_data(DMEM_AW'(40), old_word, 4'b1111);
		write_data(DMEM_AW'(40), new_word, strobe);
		read_word(DMEM_AW'(40), got);
		for (int b = 0; b < 4; b++)
			check_byte($sformatf("dmem[40] byte %0d", b), got[8*b +: 8],
				strobe[b] ? new_word[8*b +: 8] : old_word[8*b +: 8]);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module core_assertions import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic redirect,
	input logic [1:0] fwd_a,
	input logic [1:0] fwd_b,
	input logic [REG_AW-1:0] ex_rs1,
	input logic [REG_AW-1:0] ex_rs2
);

	// Bubble behind a stall never needs a second one
	assert property (@(posedge clk) disable iff (!arst_n) stall |=> !stall)
		else $error("load-use stall held for two cycles");

	// Flushed slot in execute can neither redirect nor stall
	assert property (@(posedge clk) disable iff (!arst_n) redirect |=> !redirect && !stall)
		else $error("execute slot after a redirect was not flushed");

	// x0 is never a forward target
	assert property (@(posedge clk) disable iff (!arst_n) (fwd_a != FWD_NONE) |-> (ex_rs1 != '0))
		else $error("operand A forwarded for x0");
	assert property (@(posedge clk) disable iff (!arst_n) (fwd_b != FWD_NONE) |-> (ex_rs2 != '0))
		else $error("operand B forwarded for x0");

endmodule

// Hazard interface signals seen from the top level
bind core core_assertions u_core_assertions (.clk, .arst_n, .stall(hz.stall),
	.redirect(hz.redirect), .fwd_a(hz.fwd_a), .fwd_b(hz.fwd_b),
	.ex_rs1(hz.ex_rs1), .ex_rs2(hz.ex_rs2));

`default_nettype wire

//--- source/core.sv
`timescale 1ns/10ps
`default_nettype none

module core import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic run,	// Enables the program counter
	input logic prog_write,
	input logic [IMEM_AW-1:0] prog_addr,
	input logic [XLEN-1:0] prog_data,
	input logic [3:0] con_write,
	input logic [DMEM_AW-1:0] con_addr,	// Word address
	input logic [XLEN-1:0] con_in,
	output logic [XLEN-1:0] con_out
);

	hazard_if hz ();

	// Fetch to decode
	logic [PC_W-1:0] id_pc;
	inst_t id_inst;
	logic [PC_W-1:0] redirect_pc;

	// Decode to execute
	logic [PC_W-1:0] ex_pc;
	inst_t ex_inst;
	logic [XLEN-1:0] ex_rs1_val, ex_rs2_val, ex_imm;
	logic [ALU_OP_W-1:0] ex_alu_op;
	logic ex_use_imm, ex_mem_write, ex_wr_en;
	logic [1:0] ex_wb_sel;

	// Execute to memory
	logic [XLEN-1:0] mem_alu, mem_store_data;
	logic [PC_W-1:0] mem_pc4;
	logic [REG_AW-1:0] mem_rd;
	logic mem_wr_en, mem_write;
	logic [1:0] mem_wb_sel;

	// Forward and writeback paths
	logic [XLEN-1:0] mem_result, wb_data;
	logic wb_wr_en;
	logic [REG_AW-1:0] wb_rd;

	fetch_stage u_fetch (.clk, .arst_n, .run, .prog_write, .prog_addr, .prog_data,
		.redirect_pc, .hz, .id_pc, .id_inst);

	decode_stage u_decode (.clk, .arst_n, .id_pc, .id_inst, .wb_wr_en, .wb_rd, .wb_data,
		.hz, .ex_pc, .ex_inst, .ex_rs1_val, .ex_rs2_val, .ex_imm, .ex_alu_op,
		.ex_use_imm, .ex_mem_write, .ex_wr_en, .ex_wb_sel);

	execute_stage u_execute (.clk, .arst_n, .ex_pc, .ex_inst, .ex_rs1_val, .ex_rs2_val,
		.ex_imm, .ex_alu_op, .ex_use_imm, .ex_mem_write, .ex_wr_en, .ex_wb_sel,
		.mem_result, .wb_data, .hz, .redirect_pc, .mem_alu, .mem_store_data, .mem_pc4,
		.mem_rd, .mem_wr_en, .mem_write, .mem_wb_sel);

	memory_stage u_memory (.clk, .arst_n, .mem_alu, .mem_store_data, .mem_pc4, .mem_rd,
		.mem_wr_en, .mem_write, .mem_wb_sel, .con_write, .con_addr, .con_in, .con_out,
		.hz, .mem_result, .wb_data, .wb_wr_en, .wb_rd);

	hazard_unit u_hazard (.hz);

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import core_pkg::*; (
	hazard_if.unit hz
);

	logic load_use;

	// Youngest producer wins, x0 never forwarded
	function automatic logic [1:0] fwd_sel(input logic [REG_AW-1:0] rs);
		if (rs == '0)
			return FWD_NONE;
		if (hz.mem_wr_en && hz.mem_rd == rs)
			return FWD_MEM;
		if (hz.wb_wr_en && hz.wb_rd == rs)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		hz.fwd_a = fwd_sel(hz.ex_rs1);
		hz.fwd_b = fwd_sel(hz.ex_rs2);
	end

	// Load in execute feeding the instruction in decode
	assign load_use = hz.ex_load && hz.ex_wr_en && hz.ex_rd != '0
		&& (hz.ex_rd == hz.id_rs1 || (hz.id_uses_rs2 && hz.ex_rd == hz.id_rs2));

	assign hz.stall = load_use && !hz.redirect;	// Redirect beats stall
	assign hz.flush = hz.redirect;

endmodule

`default_nettype wire

//--- source/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [XLEN-1:0] mem_alu,
	input logic [XLEN-1:0] mem_store_data,
	input logic [PC_W-1:0] mem_pc4,
	input logic [REG_AW-1:0] mem_rd,
	input logic mem_wr_en,
	input logic mem_write,
	input logic [1:0] mem_wb_sel,
	input logic [3:0] con_write,	// Byte strobes
	input logic [DMEM_AW-1:0] con_addr,
	input logic [XLEN-1:0] con_in,
	output logic [XLEN-1:0] con_out,
	hazard_if.memory hz,
	output logic [XLEN-1:0] mem_result,
	output logic [XLEN-1:0] wb_data,
	output logic wb_wr_en,
	output logic [REG_AW-1:0] wb_rd
);

	logic [XLEN-1:0] dmem [0:(1<<DMEM_AW)-1];
	logic [DMEM_AW-1:0] word_addr;
	logic [XLEN-1:0] load_data;

	assign word_addr = mem_alu[DMEM_AW+1:2];	// Word loads and stores only
	assign load_data = dmem[word_addr];

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				dmem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
		end
		// Later assignment, so a core store wins on the same word
		if (mem_write)
			dmem[word_addr] <= mem_store_data;
		con_out <= dmem[con_addr];	// Controller read, one cycle
	end

	// Result of this stage, also the forward source
	// Includes load data for a consumer two slots behind the load
	always_comb begin
		case (mem_wb_sel)
			WB_LOAD: mem_result = load_data;
			WB_PC4: mem_result = {{(XLEN-PC_W){1'b0}}, mem_pc4};
			default: mem_result = mem_alu;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_wr_en <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_wr_en <= mem_wr_en;
			wb_rd <= mem_rd;
		end
	end

	always_ff @(posedge clk)
		wb_data <= mem_result;	// Writeback value straight from here

	assign hz.mem_rd = mem_rd;
	assign hz.mem_wr_en = mem_wr_en;
	assign hz.wb_rd = wb_rd;
	assign hz.wb_wr_en = wb_wr_en;

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [PC_W-1:0] ex_pc,
	input inst_t ex_inst,
	input logic [XLEN-1:0] ex_rs1_val,
	input logic [XLEN-1:0] ex_rs2_val,
	input logic [XLEN-1:0] ex_imm,
	input logic [ALU_OP_W-1:0] ex_alu_op,
	input logic ex_use_imm,
	input logic ex_mem_write,
	input logic ex_wr_en,
	input logic [1:0] ex_wb_sel,
	input logic [XLEN-1:0] mem_result,
	input logic [XLEN-1:0] wb_data,
	hazard_if.execute hz,
	output logic [PC_W-1:0] redirect_pc,
	output logic [XLEN-1:0] mem_alu,
	output logic [XLEN-1:0] mem_store_data,
	output logic [PC_W-1:0] mem_pc4,
	output logic [REG_AW-1:0] mem_rd,
	output logic mem_wr_en,
	output logic mem_write,
	output logic [1:0] mem_wb_sel
);

	logic [XLEN-1:0] rs1_fwd, rs2_fwd, alu_b, alu_out;
	logic taken;

	function automatic logic [XLEN-1:0] fwd_pick(input logic [1:0] sel, input logic [XLEN-1:0] rf);
		case (sel)
			FWD_MEM: return mem_result;
			FWD_WB: return wb_data;
			default: return rf;
		endcase
	endfunction

	always_comb begin
		rs1_fwd = fwd_pick(hz.fwd_a, ex_rs1_val);
		rs2_fwd = fwd_pick(hz.fwd_b, ex_rs2_val);	// Also the store data
	end

	assign alu_b = ex_use_imm ? ex_imm : rs2_fwd;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_out = rs1_fwd - alu_b;
			ALU_AND: alu_out = rs1_fwd & alu_b;
			ALU_OR: alu_out = rs1_fwd | alu_b;
			ALU_XOR: alu_out = rs1_fwd ^ alu_b;
			ALU_SLT: alu_out = XLEN'($signed(rs1_fwd) < $signed(alu_b));
			ALU_SLTU: alu_out = XLEN'(rs1_fwd < alu_b);
			ALU_SLL: alu_out = rs1_fwd << alu_b[4:0];
			ALU_SRL: alu_out = rs1_fwd >> alu_b[4:0];
			ALU_SRA: alu_out = $unsigned($signed(rs1_fwd) >>> alu_b[4:0]);
			ALU_LUI: alu_out = alu_b;
			default: alu_out = rs1_fwd + alu_b;	// ALU_ADD, addresses too
		endcase
	end

	// Branch condition from funct3 of the B view
	always_comb begin
		case (ex_inst.b.funct3)
			3'd0: taken = rs1_fwd == rs2_fwd;	// BEQ
			3'd1: taken = rs1_fwd != rs2_fwd;	// BNE
			3'd4: taken = $signed(rs1_fwd) < $signed(rs2_fwd);	// BLT
			3'd5: taken = $signed(rs1_fwd) >= $signed(rs2_fwd);	// BGE
			default: taken = 1'b0;
		endcase
	end

	assign hz.redirect = (ex_inst.b.opcode == OPC_BRANCH && taken) || ex_inst.j.opcode == OPC_JAL;
	assign redirect_pc = ex_pc + ex_imm[PC_W-1:0];	// Same adder for branch and JAL

	assign hz.ex_rs1 = ex_inst.r.rs1;
	assign hz.ex_rs2 = ex_inst.r.rs2;
	assign hz.ex_rd = ex_inst.r.rd;
	assign hz.ex_wr_en = ex_wr_en;
	assign hz.ex_load = ex_wb_sel == WB_LOAD;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_rd <= '0;
			mem_wr_en <= 1'b0;
			mem_write <= 1'b0;
			mem_wb_sel <= WB_ALU;
		end else begin
			mem_rd <= ex_inst.r.rd;
			mem_wr_en <= ex_wr_en;
			mem_write <= ex_mem_write;
			mem_wb_sel <= ex_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu <= alu_out;
		mem_store_data <= rs2_fwd;
		mem_pc4 <= ex_pc + PC_W'(4);	// JAL link
	end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [PC_W-1:0] id_pc,
	input inst_t id_inst,
	input logic wb_wr_en,
	input logic [REG_AW-1:0] wb_rd,
	input logic [XLEN-1:0] wb_data,
	hazard_if.decode hz,
	output logic [PC_W-1:0] ex_pc,
	output inst_t ex_inst,
	output logic [XLEN-1:0] ex_rs1_val,
	output logic [XLEN-1:0] ex_rs2_val,
	output logic [XLEN-1:0] ex_imm,
	output logic [ALU_OP_W-1:0] ex_alu_op,
	output logic ex_use_imm,
	output logic ex_mem_write,
	output logic ex_wr_en,
	output logic [1:0] ex_wb_sel
);

	logic [XLEN-1:0] regs [0:(1<<REG_AW)-1];
	logic [REG_AW-1:0] rs1, rs2;
	logic [XLEN-1:0] rs1_val, rs2_val, imm;
	logic [ALU_OP_W-1:0] alu_op;
	logic use_imm, mem_write, wr_en, uses_rs2;
	logic [1:0] wb_sel;
	logic kill;

	// Shared by OP and OP-IMM
	function automatic logic [ALU_OP_W-1:0] alu_sel(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'd0: return alt ? ALU_SUB : ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return alt ? ALU_SRA : ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// x0 reads zero, a same-cycle writeback passes straight through
	function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] rs);
		if (rs == '0)
			return '0;
		if (wb_wr_en && wb_rd == rs)
			return wb_data;
		return regs[rs];
	endfunction

	always_comb begin
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		mem_write = 1'b0;
		wr_en = 1'b0;
		wb_sel = WB_ALU;
		uses_rs2 = 1'b0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		case (id_inst.r.opcode)
			OPC_OP: begin
				rs1 = id_inst.r.rs1;
				rs2 = id_inst.r.rs2;
				uses_rs2 = 1'b1;
				wr_en = 1'b1;
				alu_op = alu_sel(id_inst.r.funct3, id_inst.r.funct7[5]);
			end
			OPC_OPIMM: begin
				rs1 = id_inst.i.rs1;
				imm = {{20{id_inst.i.imm[11]}}, id_inst.i.imm};
				use_imm = 1'b1;
				wr_en = 1'b1;
				// Bit 30 means SRAI only; ADDI has no subtract form
				alu_op = alu_sel(id_inst.i.funct3, id_inst.i.funct3 == 3'd5 && id_inst.i.imm[10]);
			end
			OPC_LUI: begin
				imm = {id_inst.u.imm, 12'h000};
				use_imm = 1'b1;
				wr_en = 1'b1;
				alu_op = ALU_LUI;
			end
			OPC_LOAD: begin	// LW, address = rs1 + imm
				rs1 = id_inst.i.rs1;
				imm = {{20{id_inst.i.imm[11]}}, id_inst.i.imm};
				use_imm = 1'b1;
				wr_en = 1'b1;
				wb_sel = WB_LOAD;
			end
			OPC_STORE: begin	// SW
				rs1 = id_inst.s.rs1;
				rs2 = id_inst.s.rs2;
				uses_rs2 = 1'b1;
				imm = {{20{id_inst.s.imm_hi[6]}}, id_inst.s.imm_hi, id_inst.s.imm_lo};
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			OPC_BRANCH: begin	// Compare happens in execute
				rs1 = id_inst.b.rs1;
				rs2 = id_inst.b.rs2;
				uses_rs2 = 1'b1;
				imm = {{19{id_inst.b.imm12}}, id_inst.b.imm12, id_inst.b.imm11,
					id_inst.b.imm10_5, id_inst.b.imm4_1, 1'b0};
			end
			OPC_JAL: begin
				imm = {{11{id_inst.j.imm20}}, id_inst.j.imm20, id_inst.j.imm19_12,
					id_inst.j.imm11, id_inst.j.imm10_1, 1'b0};
				wr_en = 1'b1;
				wb_sel = WB_PC4;
			end
			default: ;	// Unknown opcode retires as a bubble
		endcase
		rs1_val = rf_read(rs1);
		rs2_val = rf_read(rs2);
	end

	assign hz.id_rs1 = rs1;
	assign hz.id_rs2 = rs2;
	assign hz.id_uses_rs2 = uses_rs2;

	// Register file, x0 never written
	always_ff @(posedge clk) begin
		if (wb_wr_en && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	assign kill = hz.stall || hz.flush;	// Bubble into execute

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_inst <= NOP_INST;
			ex_alu_op <= ALU_ADD;
			ex_use_imm <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_wr_en <= 1'b0;
			ex_wb_sel <= WB_ALU;
		end else begin
			ex_inst <= kill ? NOP_INST : id_inst;
			ex_alu_op <= kill ? ALU_ADD : alu_op;
			ex_use_imm <= use_imm & ~kill;
			ex_mem_write <= mem_write & ~kill;
			ex_wr_en <= wr_en & ~kill;
			ex_wb_sel <= kill ? WB_ALU : wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc <= id_pc;
		ex_rs1_val <= rs1_val;
		ex_rs2_val <= rs2_val;
		ex_imm <= imm;
	end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import core_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic prog_write,
	input logic [IMEM_AW-1:0] prog_addr,
	input logic [XLEN-1:0] prog_data,
	input logic [PC_W-1:0] redirect_pc,
	hazard_if.unit hz,	// Only stall, flush and redirect are read here
	output logic [PC_W-1:0] id_pc,
	output inst_t id_inst
);

	logic [XLEN-1:0] imem [0:(1<<IMEM_AW)-1];
	logic [PC_W-1:0] pc;
	logic [PC_W-1:0] pc_next;
	inst_t if_inst;

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_write)
			imem[prog_addr] <= prog_data;
	end

	assign if_inst = imem[pc[IMEM_AW+1:2]];	// Word addressed, combinational

	// Redirect first, then hold, then sequential
	always_comb begin
		if (hz.redirect)
			pc_next = redirect_pc;
		else if (hz.stall || !run)
			pc_next = pc;
		else
			pc_next = pc + PC_W'(4);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			id_pc <= '0;
			id_inst <= NOP_INST;
		end else begin
			pc <= pc_next;
			if (hz.flush || (!run && !hz.stall))
				id_inst <= NOP_INST;	// Nothing issued while halted
			else if (!hz.stall) begin
				id_pc <= pc;
				id_inst <= if_inst;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/hazard_if.sv
`timescale 1ns/10ps
`default_nettype none

interface hazard_if import core_pkg::*; ();

	logic [REG_AW-1:0] id_rs1;	// Zero when the field is not a source
	logic [REG_AW-1:0] id_rs2;
	logic id_uses_rs2;

	logic [REG_AW-1:0] ex_rs1;
	logic [REG_AW-1:0] ex_rs2;
	logic [REG_AW-1:0] ex_rd;
	logic ex_wr_en;
	logic ex_load;
	logic redirect;	// Taken branch or JAL in execute

	logic [REG_AW-1:0] mem_rd;
	logic mem_wr_en;
	logic [REG_AW-1:0] wb_rd;
	logic wb_wr_en;

	logic [1:0] fwd_a;	// FWD_* code for rs1
	logic [1:0] fwd_b;	// FWD_* code for rs2
	logic stall;
	logic flush;

	modport decode (output id_rs1, id_rs2, id_uses_rs2, input stall, flush);
	modport execute (output ex_rs1, ex_rs2, ex_rd, ex_wr_en, ex_load, redirect,
		input fwd_a, fwd_b);
	modport memory (output mem_rd, mem_wr_en, wb_rd, wb_wr_en);
	modport unit (input id_rs1, id_rs2, id_uses_rs2, ex_rs1, ex_rs2, ex_rd, ex_wr_en,
		ex_load, redirect, mem_rd, mem_wr_en, wb_rd, wb_wr_en,
		output fwd_a, fwd_b, stall, flush);

endinterface

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int PC_W = 12;	// Byte address into 4 KiB of program
	localparam int IMEM_AW = 10;	// 1024 instruction words
	localparam int DMEM_AW = 10;	// 1024 data words
	localparam int REG_AW = 5;
	localparam int ALU_OP_W = 4;

	// ALU operation codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_LUI = 4'd10;	// Passes operand B

	// Writeback source
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_LOAD = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2;	// JAL link value

	// Major opcodes
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// Operand source in execute
	localparam logic [1:0] FWD_NONE = 2'd0;	// Register file value
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB = 2'd2;

	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;	// ADDI x0, x0, 0

	// One instruction word, one view per format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [REG_AW-1:0] rs2;
			logic [REG_AW-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_AW-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [REG_AW-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_AW-1:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [REG_AW-1:0] rs2;
			logic [REG_AW-1:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [REG_AW-1:0] rs2;
			logic [REG_AW-1:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [REG_AW-1:0] rd;
			logic [6:0] opcode;
		} u;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [REG_AW-1:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

endpackage

`default_nettype wire
